// ==== sim.f ====
hw/vec_isa_pkg.sv
hw/vec_core_pkg.sv
hw/tail_be_gen.sv
hw/vec_cfg.sv
hw/vec_regfile.sv
hw/vec_alu.sv
hw/vec_ctrl.sv
hw/vec_core.sv
testbench/vec_core_tb.sv

// ==== Bender.yml ====
package:
  name: vec_core

sources:
  - hw/vec_isa_pkg.sv
  - hw/vec_core_pkg.sv
  - hw/tail_be_gen.sv
  - hw/vec_cfg.sv
  - hw/vec_regfile.sv
  - hw/vec_alu.sv
  - hw/vec_ctrl.sv
  - hw/vec_core.sv
  - target: simulation
    files:
      - testbench/vec_core_tb.sv

// ==== testbench/vec_core_tb.sv ====
module vec_core_tb
    import vec_isa_pkg::*;
    import vec_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VLEN           = DEF_VLEN;
    localparam int DATA_WIDTH     = DEF_DATA_WIDTH;
    localparam int DW_B           = DATA_WIDTH / 8;
    localparam int VLEN_B         = VLEN / 8;
    localparam int TIMEOUT_CYCLES = 4000;   // about four times the sum of all tests

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           insn;
    logic                  insn_valid;
    xlen_t                 scalar_in;
    logic                  proc_rdy;
    xlen_t                 scalar_out;
    logic                  scalar_valid;
    logic                  mem_valid;
    xlen_t                 mem_addr;
    logic [DATA_WIDTH-1:0] mem_data;
    logic [DW_B-1:0]       mem_be;

    logic [7:0] ref_regs [NUM_VREG][VLEN_B];   // reference model, bytes of each register
    int         ref_vl;
    sew_t       ref_sew;

    xlen_t                 cap_addr [$];   // store beats in arrival order
    logic [DATA_WIDTH-1:0] cap_data [$];
    logic [DW_B-1:0]       cap_be [$];
    int                    pulses;
    xlen_t                 last_scalar;

    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    integer seed   = 67;

    vec_core #(.VLEN(VLEN), .DATA_WIDTH(DATA_WIDTH)) u_dut (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .scalar_in(scalar_in), .proc_rdy(proc_rdy), .scalar_out(scalar_out),
        .scalar_valid(scalar_valid), .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_data(mem_data), .mem_be(mem_be)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // outputs are sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (rst_n && mem_valid) begin
            cap_addr.push_back(mem_addr);
            cap_data.push_back(mem_data);
            cap_be.push_back(mem_be);
        end
        if (rst_n && scalar_valid) begin
            pulses      = pulses + 1;
            last_scalar = scalar_out;
        end
    end

    task automatic report_error(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_vl(input xlen_t got, input xlen_t exp, input string what);
        checks++;
        if (got !== exp)
            report_error($sformatf("%s returned vl %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_beat(input xlen_t addr, input logic [DATA_WIDTH-1:0] data,
                              input logic [DW_B-1:0] be, input xlen_t exp_addr,
                              input logic [DATA_WIDTH-1:0] exp_data,
                              input logic [DW_B-1:0] exp_be, input int k);
        checks++;
        if (addr !== exp_addr || data !== exp_data || be !== exp_be)
            report_error($sformatf("beat %0d addr %h data %h be %b, expected %h %h %b",
                                   k, addr, data, be, exp_addr, exp_data, exp_be));
    endtask

    task automatic expect_level(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    function automatic logic [63:0] read_elem(input int r, input int i);
        int          eb;
        logic [63:0] v;
        eb = 1 << int'(ref_sew);
        v  = '0;
        for (int j = 0; j < eb; j++)
            v[8*j +: 8] = ref_regs[r][i*eb + j];
        return v;
    endfunction

    function automatic void write_elem(input int r, input int i, input logic [63:0] v);
        int eb;
        eb = 1 << int'(ref_sew);
        for (int j = 0; j < eb; j++)
            ref_regs[r][i*eb + j] = v[8*j +: 8];
    endfunction

    task automatic wait_idle();
        do
            @(negedge clk);
        while (!proc_rdy);
        @(posedge clk);
        #10;
    endtask

    // held on insn until the unit takes it
    task automatic issue_insn(input logic [31:0] word, input xlen_t scal);
        insn       = word;
        scalar_in  = scal;
        insn_valid = 1'b1;
        do
            @(negedge clk);
        while (!proc_rdy);
        @(posedge clk);
        #10;
        insn_valid = 1'b0;
        insn       = '0;
    endtask

    task automatic set_vl(input logic [2:0] vsew, input logic [2:0] vlmul, input bit rs1_zero,
                          input xlen_t avl);
        logic [4:0] rs1f;
        int         vlmax;
        int         exp_vl;
        rs1f        = rs1_zero ? 5'd0 : 5'd11;
        pulses      = 0;
        last_scalar = '1;
        issue_insn({1'b0, 5'd0, vlmul, vsew, rs1f, OPCFG, 5'd5, OP_VEC}, avl);
        if (vsew[2] || vlmul != 3'd0) begin
            exp_vl  = 0;
            ref_sew = SEW8;
        end else begin
            vlmax   = VLEN_B >> vsew;
            exp_vl  = (rs1_zero || avl >= vlmax) ? vlmax : int'(avl);
            ref_sew = sew_t'(vsew[1:0]);
        end
        ref_vl = exp_vl;
        wait_idle();
        check_vl(last_scalar, xlen_t'(exp_vl), "vsetvli");
        if (pulses != 1)
            report_error($sformatf("scalar_valid pulsed %0d times for one vsetvli", pulses));
    endtask

    task automatic run_alu(input vfunct6_t op, input vfunct3_t form, input int vd,
                           input int vs2, input int rs1, input xlen_t scal);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [63:0] splat;
        logic [63:0] mask;
        logic [4:0]  imm5;
        int          eb;
        issue_insn({op, 1'b1, 5'(vs2), 5'(rs1), form, 5'(vd), OP_VEC}, scal);
        eb    = 1 << int'(ref_sew);
        mask  = (eb == 8) ? '1 : (64'd1 << (8 * eb)) - 64'd1;
        imm5  = 5'(rs1);
        splat = (form == OPIVI) ? {{59{imm5[4]}}, imm5} : {{32{scal[31]}}, scal};
        for (int i = 0; i < ref_vl; i++) begin   // tail elements untouched
            b = read_elem(vs2, i);
            a = (form == OPIVV) ? read_elem(rs1, i) : splat;
            case (op)
                F_VADD:  r = b + a;
                F_VSUB:  r = b - a;
                F_VAND:  r = b & a;
                F_VOR:   r = b | a;
                default: r = b ^ a;
            endcase
            write_elem(vd, i, r & mask);
        end
        wait_idle();
    endtask

    task automatic launch_store(input int vs3, input xlen_t base);
        cap_addr.delete();
        cap_data.delete();
        cap_be.delete();
        issue_insn({6'd0, 1'b1, 5'd0, 5'd10, 3'b000, 5'(vs3), OP_STORE}, base);
    endtask

    task automatic check_store(input int vs3, input xlen_t base);
        int                    n;
        logic [DATA_WIDTH-1:0] exp_data;
        logic [DW_B-1:0]       exp_be;
        wait_idle();
        n = ((ref_vl << int'(ref_sew)) + DW_B - 1) / DW_B;
        if (n == 0)
            n = 1;
        if (cap_addr.size() != n)
            report_error($sformatf("store of v%0d gave %0d beats, expected %0d",
                                   vs3, cap_addr.size(), n));
        for (int k = 0; k < n && k < cap_addr.size(); k++) begin
            for (int j = 0; j < DW_B; j++) begin
                exp_data[8*j +: 8] = ref_regs[vs3][k*DW_B + j];
                exp_be[j]          = ((k*DW_B + j) >> int'(ref_sew)) < ref_vl;
            end
            check_beat(cap_addr[k], cap_data[k], cap_be[k], base + xlen_t'(k*DW_B),
                       exp_data, exp_be, k);
        end
    endtask

    task automatic store_reg(input int vs3, input xlen_t base);
        launch_store(vs3, base);
        check_store(vs3, base);
    endtask

    task automatic end_test(input string name, input int err0);
        $display("%-14s done, %0d errors", name, errors - err0);
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        @(negedge clk);
        expect_level(proc_rdy, 1'b1, "proc_rdy after reset");
        expect_level(scalar_valid, 1'b0, "scalar_valid after reset");
        expect_level(mem_valid, 1'b0, "mem_valid after reset");
        @(posedge clk);
        #10;
        store_reg(1, 32'h100);   // vl 0, one beat with no byte enabled
        set_vl(3'd0, 3'd0, 1'b1, '0);
        store_reg(0, 32'h200);
        store_reg(17, 32'h300);
        store_reg(31, 32'h400);
        end_test("reset_state", err0);
    endtask

    task automatic config_vl();
        int err0;
        err0 = errors;
        for (int s = 0; s < 4; s++) begin
            set_vl(3'(s), 3'd0, 1'b0, xlen_t'($random(seed)) & 32'h3f);
            set_vl(3'(s), 3'd0, 1'b0, 32'd3);
            set_vl(3'(s), 3'd0, 1'b1, 32'd5);   // rs1 of zero asks for vlmax
        end
        set_vl(3'd4, 3'd0, 1'b0, 32'd8);
        set_vl(3'd1, 3'd1, 1'b0, 32'd8);
        end_test("config_vl", err0);
    endtask

    task automatic splat_forms();
        int err0;
        err0 = errors;
        for (int s = 0; s < 4; s++) begin
            set_vl(3'(s), 3'd0, 1'b1, '0);
            run_alu(F_VADD, OPIVI, 1, 0, $random(seed) & 31, '0);
            run_alu(F_VADD, OPIVX, 2, 0, 1, $random(seed));
            store_reg(1, 32'h1000);
            store_reg(2, 32'h1100);
        end
        end_test("splat_forms", err0);
    endtask

    task automatic vv_arith();
        int       err0;
        vfunct6_t ops [5];
        err0 = errors;
        ops  = '{F_VADD, F_VSUB, F_VAND, F_VOR, F_VXOR};
        set_vl(3'd3, 3'd0, 1'b1, '0);
        run_alu(F_VXOR, OPIVX, 3, 3, 1, $random(seed));
        run_alu(F_VXOR, OPIVX, 4, 4, 1, $random(seed));
        // partial updates at mixed widths leave uneven element values
        for (int j = 0; j < 6; j++) begin
            set_vl(3'($random(seed) & 3), 3'd0, 1'b0, $random(seed) & 31);
            run_alu(F_VXOR, OPIVX, 3, 3, 1, $random(seed));
            run_alu(F_VADD, OPIVX, 4, 4, 1, $random(seed));
        end
        for (int s = 0; s < 4; s++) begin
            set_vl(3'(s), 3'd0, 1'b1, '0);
            for (int o = 0; o < 5; o++) begin
                run_alu(ops[o], OPIVV, 5 + o, 3, 4, '0);
                store_reg(5 + o, 32'h2000 + 32'(o * 64));
            end
        end
        set_vl(3'd0, 3'd0, 1'b1, '0);
        run_alu(F_VADD, OPIVI, 10, 0, 31, '0);   // every byte 0xff
        run_alu(F_VADD, OPIVI, 12, 0, 1, '0);
        for (int s = 0; s < 4; s++) begin
            set_vl(3'(s), 3'd0, 1'b1, '0);
            run_alu(F_VADD, OPIVV, 11, 10, 12, '0);   // carry out of each element
            store_reg(11, 32'h3000);
            run_alu(F_VSUB, OPIVV, 11, 0, 12, '0);    // borrow through each element
            store_reg(11, 32'h3100);
        end
        end_test("vv_arith", err0);
    endtask

    task automatic tail_enables();
        int err0;
        err0 = errors;
        set_vl(3'd0, 3'd0, 1'b1, '0);
        run_alu(F_VADD, OPIVI, 13, 0, 31, '0);
        set_vl(3'd1, 3'd0, 1'b0, 32'd5);
        run_alu(F_VADD, OPIVI, 13, 13, 1, '0);
        store_reg(13, 32'h4000);
        set_vl(3'd2, 3'd0, 1'b0, 32'd3);
        run_alu(F_VXOR, OPIVX, 13, 13, 1, $random(seed));
        store_reg(13, 32'h4100);
        set_vl(3'd0, 3'd0, 1'b1, '0);   // full length shows the kept tail bytes
        store_reg(13, 32'h4200);
        end_test("tail_enables", err0);
    endtask

    task automatic held_insn();
        int    err0;
        xlen_t base;
        err0 = errors;
        base = $random(seed);
        set_vl(3'd2, 3'd0, 1'b1, '0);
        launch_store(13, base);
        run_alu(F_VADD, OPIVI, 14, 14, 1, '0);   // offered while the store runs
        check_store(13, base);
        store_reg(14, 32'h5000);
        set_vl(3'd3, 3'd0, 1'b0, 32'd3);
        store_reg(14, $random(seed));
        end_test("held_insn", err0);
    endtask

    initial begin
        insn       = '0;
        insn_valid = 1'b0;
        scalar_in  = '0;
        rst_n      = 1'b0;
        pulses     = 0;
        ref_vl     = 0;
        ref_sew    = SEW8;
        for (int r = 0; r < NUM_VREG; r++)
            for (int i = 0; i < VLEN_B; i++)
                ref_regs[r][i] = 8'h00;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        reset_state();
        config_vl();
        splat_forms();
        vv_arith();
        tail_enables();
        held_insn();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hw/vec_core.sv ====
module vec_core
    import vec_isa_pkg::*;
    import vec_core_pkg::*;
#(
    parameter int  VLEN       = DEF_VLEN,
    parameter int  DATA_WIDTH = DEF_DATA_WIDTH,
    localparam int NUM_BEATS  = VLEN / DATA_WIDTH,
    localparam int BEAT_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1,
    localparam int DW_B       = DATA_WIDTH / 8,
    localparam int VL_W       = $clog2(VLEN / 8) + 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           insn,
    input  logic                  insn_valid,
    input  xlen_t                 scalar_in,
    output logic                  proc_rdy,
    output xlen_t                 scalar_out,
    output logic                  scalar_valid,
    output logic                  mem_valid,
    output xlen_t                 mem_addr,
    output logic [DATA_WIDTH-1:0] mem_data,
    output logic [DW_B-1:0]       mem_be
);

    logic [VL_W-1:0]       vl;
    sew_t                  sew;
    logic [DW_B-1:0]       beat_be;
    logic                  cfg_en;
    logic [VTYPE_W-1:0]    cfg_vtype;
    xlen_t                 cfg_avl;
    logic                  cfg_rs1_zero;
    vreg_addr_t            rd_addr_1;
    vreg_addr_t            rd_addr_2;
    logic [BEAT_W-1:0]     rd_beat;
    logic [BEAT_W-1:0]     beat_idx;
    logic                  alu_valid;
    vfunct6_t              alu_op;
    vfunct3_t              alu_form;
    xlen_t                 alu_scalar;
    logic [4:0]            alu_imm;
    vreg_addr_t            alu_vd;
    logic [DW_B-1:0]       alu_be;
    logic [DATA_WIDTH-1:0] rd_data_1;
    logic [DATA_WIDTH-1:0] rd_data_2;
    logic                  wr_en;
    vreg_addr_t            wr_addr;
    logic [BEAT_W-1:0]     wr_beat;
    logic [DW_B-1:0]       wr_be;
    logic [DATA_WIDTH-1:0] wr_data;

    assign mem_data = rd_data_1;   // store data comes straight off read port 1

    vec_ctrl #(.VLEN(VLEN), .DATA_WIDTH(DATA_WIDTH)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .insn(insn), .insn_valid(insn_valid),
        .scalar_in(scalar_in), .vl(vl), .sew(sew), .beat_be(beat_be), .proc_rdy(proc_rdy),
        .cfg_en(cfg_en), .cfg_vtype(cfg_vtype), .cfg_avl(cfg_avl), .cfg_rs1_zero(cfg_rs1_zero),
        .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2), .rd_beat(rd_beat), .beat_idx(beat_idx),
        .alu_valid(alu_valid), .alu_op(alu_op), .alu_form(alu_form), .alu_scalar(alu_scalar),
        .alu_imm(alu_imm), .alu_vd(alu_vd), .alu_be(alu_be), .scalar_valid(scalar_valid),
        .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_be(mem_be)
    );

    vec_cfg #(.VLEN(VLEN)) u_cfg (
        .clk(clk), .rst_n(rst_n), .cfg_en(cfg_en), .cfg_vtype(cfg_vtype), .cfg_avl(cfg_avl),
        .cfg_rs1_zero(cfg_rs1_zero), .vl(vl), .sew(sew), .vill(), .scalar_out(scalar_out)
    );

    vec_regfile #(.VLEN(VLEN), .DATA_WIDTH(DATA_WIDTH)) u_regfile (
        .clk(clk), .rst_n(rst_n), .rd_addr_1(rd_addr_1), .rd_addr_2(rd_addr_2),
        .rd_beat(rd_beat), .wr_en(wr_en), .wr_addr(wr_addr), .wr_beat(wr_beat), .wr_be(wr_be),
        .wr_data(wr_data), .rd_data_1(rd_data_1), .rd_data_2(rd_data_2)
    );

    vec_alu #(.VLEN(VLEN), .DATA_WIDTH(DATA_WIDTH)) u_alu (
        .clk(clk), .rst_n(rst_n), .valid(alu_valid), .op(alu_op), .form(alu_form), .sew(sew),
        .scalar(alu_scalar), .imm(alu_imm), .vd(alu_vd), .beat(beat_idx), .be(alu_be),
        .src_a(rd_data_1), .src_b(rd_data_2), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_beat(wr_beat), .wr_be(wr_be), .wr_data(wr_data)
    );

    tail_be_gen #(.VLEN(VLEN), .DATA_WIDTH(DATA_WIDTH)) u_tail_be (
        .vl(vl), .sew(sew), .beat_idx(beat_idx), .beat_be(beat_be)
    );

endmodule

// ==== hw/vec_ctrl.sv ====
module vec_ctrl
    import vec_isa_pkg::*;
    import vec_core_pkg::*;
#(
    parameter int  VLEN       = DEF_VLEN,
    parameter int  DATA_WIDTH = DEF_DATA_WIDTH,
    localparam int NUM_BEATS  = VLEN / DATA_WIDTH,
    localparam int BEAT_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1,
    localparam int CNT_W      = $clog2(NUM_BEATS) + 1,
    localparam int DW_B       = DATA_WIDTH / 8,
    localparam int DWB_W      = $clog2(DW_B),
    localparam int VL_W       = $clog2(VLEN / 8) + 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        insn,
    input  logic               insn_valid,
    input  xlen_t              scalar_in,
    input  logic [VL_W-1:0]    vl,
    input  sew_t               sew,
    input  logic [DW_B-1:0]    beat_be,
    output logic               proc_rdy,
    output logic               cfg_en,
    output logic [VTYPE_W-1:0] cfg_vtype,
    output xlen_t              cfg_avl,
    output logic               cfg_rs1_zero,
    output vreg_addr_t         rd_addr_1,
    output vreg_addr_t         rd_addr_2,
    output logic [BEAT_W-1:0]  rd_beat,
    output logic [BEAT_W-1:0]  beat_idx,
    output logic               alu_valid,
    output vfunct6_t           alu_op,
    output vfunct3_t           alu_form,
    output xlen_t              alu_scalar,
    output logic [4:0]         alu_imm,
    output vreg_addr_t         alu_vd,
    output logic [DW_B-1:0]    alu_be,
    output logic               scalar_valid,
    output logic               mem_valid,
    output xlen_t              mem_addr,
    output logic [DW_B-1:0]    mem_be
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,   // one register read per cycle
        ST_DRAIN    // results still behind the last read
    } state_t;

    state_t            state;
    logic [31:0]       insn_q;
    xlen_t             scalar_q;
    logic [CNT_W-1:0]  beats_left;
    logic [BEAT_W-1:0] issue_beat;
    logic              drain_more;
    major_op_t         opcode;
    vfunct3_t          form;
    vreg_addr_t        vd_f;
    vreg_addr_t        rs1_f;
    logic              is_cfg;
    logic              is_alu;
    logic              is_store;
    logic              issuing;
    logic [VL_W-1:0]   vl_bytes;
    logic [CNT_W-1:0]  n_beats;

    assign opcode = major_op_t'(insn_q[OPC_LSB +: 7]);
    assign form   = vfunct3_t'(insn_q[F3_LSB +: 3]);
    assign vd_f   = insn_q[VD_LSB +: 5];
    assign rs1_f  = insn_q[RS1_LSB +: 5];

    always_comb begin
        is_cfg   = 1'b0;
        is_alu   = 1'b0;
        is_store = 1'b0;
        case (opcode)
            OP_STORE: is_store = 1'b1;
            OP_VEC: begin
                case (form)
                    OPIVV, OPIVI, OPIVX: is_alu = 1'b1;
                    OPCFG:               is_cfg = 1'b1;
                    default: ;
                endcase
            end
            default: ;   // anything else retires without effect
        endcase
    end

    // beats for the current vl, never fewer than one
    assign vl_bytes = vl << sew;
    always_comb begin
        n_beats = CNT_W'((vl_bytes + DW_B - 1) >> DWB_W);
        if (n_beats == '0)
            n_beats = CNT_W'(1);
    end

    assign proc_rdy = (state == ST_IDLE);
    assign issuing  = (state == ST_ISSUE) && (is_alu || is_store);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            insn_q     <= '0;
            beats_left <= '0;
            issue_beat <= '0;
            drain_more <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (insn_valid) begin
                        state      <= ST_ISSUE;
                        insn_q     <= insn;
                        beats_left <= n_beats;
                        issue_beat <= '0;
                    end
                end
                ST_ISSUE: begin
                    beats_left <= beats_left - 1'b1;
                    issue_beat <= issue_beat + 1'b1;
                    if (!issuing) begin
                        state      <= is_cfg ? ST_DRAIN : ST_IDLE;   // vsetvli waits for scalar_valid
                        drain_more <= 1'b0;
                    end else if (beats_left == CNT_W'(1)) begin
                        state      <= ST_DRAIN;
                        drain_more <= is_alu;   // writeback is one stage behind store data
                    end
                end
                ST_DRAIN: begin
                    drain_more <= 1'b0;
                    if (!drain_more)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (proc_rdy && insn_valid)
            scalar_q <= scalar_in;
    end

    assign cfg_en       = (state == ST_ISSUE) && is_cfg;
    assign cfg_vtype    = insn_q[VTYPE_LSB +: VTYPE_W];
    assign cfg_avl      = scalar_q;
    assign cfg_rs1_zero = (rs1_f == '0);
    assign rd_addr_1    = is_store ? vd_f : rs1_f;   // vs3 for stores
    assign rd_addr_2    = insn_q[VS2_LSB +: 5];
    assign rd_beat      = issue_beat;
    assign alu_op       = vfunct6_t'(insn_q[F6_LSB +: 6]);
    assign alu_form     = form;
    assign alu_scalar   = scalar_q;
    assign alu_imm      = rs1_f;
    assign alu_be       = alu_valid ? beat_be : '0;
    assign mem_be       = mem_valid ? beat_be : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid    <= 1'b0;
            mem_valid    <= 1'b0;
            scalar_valid <= 1'b0;
        end else begin
            alu_valid    <= issuing && is_alu;
            mem_valid    <= issuing && is_store;
            scalar_valid <= cfg_en;   // vl is updated at the same edge
        end
    end

    // one cycle behind the read address, lined up with the read data
    always_ff @(posedge clk) begin
        beat_idx <= issue_beat;
        alu_vd   <= vd_f;
        mem_addr <= scalar_q + (xlen_t'(issue_beat) << DWB_W);
    end

endmodule

// ==== hw/vec_alu.sv ====
module vec_alu
    import vec_isa_pkg::*;
    import vec_core_pkg::*;
#(
    parameter int  VLEN       = DEF_VLEN,
    parameter int  DATA_WIDTH = DEF_DATA_WIDTH,
    localparam int NUM_BEATS  = VLEN / DATA_WIDTH,
    localparam int BEAT_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1,
    localparam int DW_B       = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid,
    input  vfunct6_t              op,
    input  vfunct3_t              form,
    input  sew_t                  sew,
    input  xlen_t                 scalar,
    input  logic [4:0]            imm,
    input  vreg_addr_t            vd,
    input  logic [BEAT_W-1:0]     beat,
    input  logic [DW_B-1:0]       be,
    input  logic [DATA_WIDTH-1:0] src_a,
    input  logic [DATA_WIDTH-1:0] src_b,
    output logic                  wr_en,
    output vreg_addr_t            wr_addr,
    output logic [BEAT_W-1:0]     wr_beat,
    output logic [DW_B-1:0]       wr_be,
    output logic [DATA_WIDTH-1:0] wr_data
);

    logic [63:0]           splat_src;   // one element, sign-extended to 64 bits
    logic [2:0]            esz_m1;
    logic [2:0]            lane_base;
    logic [2:0]            byte_pos [DW_B];
    logic [DATA_WIDTH-1:0] opa;
    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] result;
    logic                  is_sub;
    logic                  carry_out;
    logic                  carry_q;   // carry into the next beat of a wide element

    assign is_sub    = (op == F_VSUB);
    assign esz_m1    = 3'((4'd1 << sew) - 4'd1);
    assign lane_base = 3'(beat * DW_B);   // nonzero only when a beat is narrower than 64 bits
    assign splat_src = (form == OPIVI) ? {{59{imm[4]}}, imm}
                                       : {{(64 - XLEN){scalar[XLEN-1]}}, scalar};

    always_comb begin
        for (int b = 0; b < DW_B; b++) begin
            byte_pos[b] = (lane_base + 3'(b)) & esz_m1;   // byte index inside its element
            if (form == OPIVV)
                opa[8*b +: 8] = src_a[8*b +: 8];
            else
                opa[8*b +: 8] = splat_src[8*byte_pos[b] +: 8];
        end
    end

    // byte-serial add, carry restarts at each element
    always_comb begin : add_chain
        logic [7:0] a_byte;
        logic [8:0] sum9;
        logic       carry;
        carry = carry_q;
        for (int b = 0; b < DW_B; b++) begin
            if (byte_pos[b] == 3'd0)
                carry = is_sub;
            a_byte        = is_sub ? ~opa[8*b +: 8] : opa[8*b +: 8];
            sum9          = {1'b0, src_b[8*b +: 8]} + {1'b0, a_byte} + {8'd0, carry};
            sum[8*b +: 8] = sum9[7:0];
            carry         = sum9[8];
        end
        carry_out = carry;
    end

    always_comb begin
        case (op)
            F_VAND:  result = src_b & opa;
            F_VOR:   result = src_b | opa;
            F_VXOR:  result = src_b ^ opa;
            default: result = sum;   // add and sub
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            wr_en <= 1'b0;
        else
            wr_en <= valid;
    end

    always_ff @(posedge clk) begin
        wr_addr <= vd;
        wr_beat <= beat;
        wr_be   <= be;
        wr_data <= result;
        if (valid)
            carry_q <= carry_out;
    end

endmodule

// ==== hw/vec_regfile.sv ====
module vec_regfile
    import vec_isa_pkg::*;
    import vec_core_pkg::*;
#(
    parameter int  VLEN       = DEF_VLEN,
    parameter int  DATA_WIDTH = DEF_DATA_WIDTH,
    localparam int NUM_BEATS  = VLEN / DATA_WIDTH,
    localparam int BEAT_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1,
    localparam int DW_B       = DATA_WIDTH / 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  vreg_addr_t            rd_addr_1,
    input  vreg_addr_t            rd_addr_2,
    input  logic [BEAT_W-1:0]     rd_beat,
    input  logic                  wr_en,
    input  vreg_addr_t            wr_addr,
    input  logic [BEAT_W-1:0]     wr_beat,
    input  logic [DW_B-1:0]       wr_be,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic [DATA_WIDTH-1:0] rd_data_1,
    output logic [DATA_WIDTH-1:0] rd_data_2
);

    logic [DATA_WIDTH-1:0] regs [NUM_VREG][NUM_BEATS];   // register, then beat

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_VREG; r++)
                for (int b = 0; b < NUM_BEATS; b++)
                    regs[r][b] <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < DW_B; i++)
                if (wr_be[i])
                    regs[wr_addr][wr_beat][8*i +: 8] <= wr_data[8*i +: 8];
        end
    end

    // both ports read the same beat, one cycle later
    always_ff @(posedge clk) begin
        rd_data_1 <= regs[rd_addr_1][rd_beat];
        rd_data_2 <= regs[rd_addr_2][rd_beat];
    end

endmodule

// ==== hw/vec_cfg.sv ====
module vec_cfg
    import vec_isa_pkg::*;
    import vec_core_pkg::*;
#(
    parameter int  VLEN = DEF_VLEN,
    localparam int VL_W = $clog2(VLEN / 8) + 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_en,
    input  logic [VTYPE_W-1:0] cfg_vtype,
    input  xlen_t              cfg_avl,
    input  logic               cfg_rs1_zero,
    output logic [VL_W-1:0]    vl,
    output sew_t               sew,
    output logic               vill,
    output xlen_t              scalar_out
);

    sew_t            new_sew;
    logic            bad_vtype;
    logic [VL_W-1:0] vlmax;

    assign new_sew   = sew_t'(cfg_vtype[1:0]);
    assign bad_vtype = cfg_vtype[2] | (|cfg_vtype[5:3]);   // vsew above 3 or any lmul but 1
    assign vlmax     = VL_W'(VLEN / 8) >> new_sew;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vl   <= '0;
            sew  <= SEW8;
            vill <= 1'b1;   // no legal vtype set yet
        end else if (cfg_en) begin
            vill <= bad_vtype;
            if (bad_vtype) begin
                vl  <= '0;
                sew <= SEW8;
            end else begin
                sew <= new_sew;
                if (cfg_rs1_zero || cfg_avl >= xlen_t'(vlmax))
                    vl <= vlmax;
                else
                    vl <= cfg_avl[VL_W-1:0];
            end
        end
    end

    assign scalar_out = vill ? '0 : xlen_t'(vl);

endmodule

// ==== hw/tail_be_gen.sv ====
module tail_be_gen
    import vec_core_pkg::*;
#(
    parameter int  VLEN       = DEF_VLEN,
    parameter int  DATA_WIDTH = DEF_DATA_WIDTH,
    localparam int NUM_BEATS  = VLEN / DATA_WIDTH,
    localparam int BEAT_W     = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1,
    localparam int DW_B       = DATA_WIDTH / 8,
    localparam int VL_W       = $clog2(VLEN / 8) + 1
) (
    input  logic [VL_W-1:0]   vl,
    input  sew_t              sew,
    input  logic [BEAT_W-1:0] beat_idx,
    output logic [DW_B-1:0]   beat_be
);

    // a byte is live when the element holding it lies below vl
    always_comb begin : be_loop
        logic [31:0] byte_addr;
        for (int b = 0; b < DW_B; b++) begin
            byte_addr  = 32'(beat_idx) * DW_B + b;   // byte offset in the register
            beat_be[b] = (byte_addr >> sew) < 32'(vl);
        end
    end

endmodule

// ==== hw/vec_core_pkg.sv ====
package vec_core_pkg;

    localparam int XLEN     = 32;   // scalar side
    localparam int NUM_VREG = 32;

    // sizes used when the top level is not overridden
    localparam int DEF_VLEN       = 256;
    localparam int DEF_DATA_WIDTH = 64;

    typedef logic [XLEN-1:0] xlen_t;

    // element width, same code as vsew
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2,
        SEW64 = 2'd3
    } sew_t;

endpackage

// ==== hw/vec_isa_pkg.sv ====
package vec_isa_pkg;

    // major opcodes handled by the unit
    typedef enum logic [6:0] {
        OP_STORE = 7'h27,   // unit-stride store only
        OP_VEC   = 7'h57    // arithmetic and vsetvli
    } major_op_t;

    // operand form, funct3 of OP-V
    typedef enum logic [2:0] {
        OPIVV = 3'h0,
        OPIVI = 3'h3,
        OPIVX = 3'h4,
        OPCFG = 3'h7
    } vfunct3_t;

    typedef enum logic [5:0] {
        F_VADD = 6'b000000,
        F_VSUB = 6'b000010,   // vs2 minus the first operand
        F_VAND = 6'b001001,
        F_VOR  = 6'b001010,
        F_VXOR = 6'b001011
    } vfunct6_t;

    typedef logic [4:0] vreg_addr_t;

    // field positions in the 32-bit instruction word
    localparam int OPC_LSB   = 0;
    localparam int VD_LSB    = 7;    // vd, or vs3 of a store
    localparam int F3_LSB    = 12;
    localparam int RS1_LSB   = 15;   // rs1, vs1 or simm5
    localparam int VS2_LSB   = 20;
    localparam int F6_LSB    = 26;
    localparam int VTYPE_LSB = 20;   // zimm of vsetvli
    localparam int VTYPE_W   = 11;

endpackage
